/* hdl/y86_pkg.sv */
package y86_pkg;

	localparam int word_w = 64;
	localparam int reg_w = 4;
	localparam int imem_depth = 256;
	localparam int pc_w = 64;

	localparam logic [reg_w-1:0] rnone = 4'hf; // no register

	typedef enum logic [3:0] {
		i_halt   = 4'h0,
		i_nop    = 4'h1,
		i_rrmovq = 4'h2, // cmovXX too
		i_irmovq = 4'h3,
		i_rmmovq = 4'h4,
		i_mrmovq = 4'h5,
		i_opq    = 4'h6,
		i_jxx    = 4'h7,
		i_call   = 4'h8,
		i_ret    = 4'h9,
		i_pushq  = 4'ha,
		i_popq   = 4'hb
	} icode_t;

	typedef enum logic [3:0] {
		alu_add = 4'h0,
		alu_sub = 4'h1,
		alu_and = 4'h2,
		alu_xor = 4'h3
	} alu_fun_t;

	typedef enum logic [3:0] {
		c_always = 4'h0,
		c_le     = 4'h1,
		c_l      = 4'h2,
		c_e      = 4'h3,
		c_ne     = 4'h4,
		c_ge     = 4'h5,
		c_g      = 4'h6
	} cond_t;

	// status codes, same encoding as the Stat bus
	typedef enum logic [1:0] {
		s_aok = 2'h0,
		s_hlt = 2'h1,
		s_adr = 2'h2,
		s_ins = 2'h3
	} stat_t;

endpackage

/* hdl/y86_fetch.sv */
`timescale 1ns/1ps

module y86_fetch (
	input  logic                             CLK,
	input  logic                             reset,
	input  logic                             prog_we,
	input  logic [7:0]                       prog_addr,
	input  logic [7:0]                       prog_data,
	input  logic                             mispredict,
	input  logic [y86_pkg::pc_w-1:0]         redirect_pc,
	input  y86_pkg::stat_t                   w_stat,
	output y86_pkg::stat_t                   d_stat,
	output y86_pkg::icode_t                  d_icode,
	output logic [3:0]                       d_ifun,
	output logic [y86_pkg::reg_w-1:0]        d_ra,
	output logic [y86_pkg::reg_w-1:0]        d_rb,
	output logic [y86_pkg::word_w-1:0]       d_valc,
	output logic [y86_pkg::pc_w-1:0]         d_valp
);

	logic [7:0] imem [y86_pkg::imem_depth];
	logic [7:0] ibytes [10];

	logic [y86_pkg::pc_w-1:0]   pred_pc;
	logic [y86_pkg::pc_w-1:0]   f_pc;
	logic [y86_pkg::pc_w-1:0]   f_pred;
	logic [y86_pkg::pc_w-1:0]   f_valp;
	logic [y86_pkg::word_w-1:0] f_valc;
	logic [y86_pkg::reg_w-1:0]  f_ra;
	logic [y86_pkg::reg_w-1:0]  f_rb;
	y86_pkg::icode_t            f_icode;
	logic [3:0]                 f_ifun;
	y86_pkg::stat_t             f_stat;
	logic need_regids;
	logic need_valc;
	logic imem_error;
	logic instr_valid;
	logic frozen;

	always_ff @(posedge CLK)
	begin
		if (prog_we)
			imem[prog_addr] <= prog_data;
	end

	assign f_pc = pred_pc;
	assign imem_error = (f_pc[y86_pkg::pc_w-1:$clog2(y86_pkg::imem_depth)] != '0);

	// ten bytes wrapping inside the memory
	always_comb
	begin
		for (int k = 0; k < 10; k++)
			ibytes[k] = imem[f_pc[$clog2(y86_pkg::imem_depth)-1:0] + 8'(k)];
	end

	assign f_icode = y86_pkg::icode_t'(ibytes[0][7:4]);
	assign f_ifun = ibytes[0][3:0];

	assign need_regids = (f_icode == y86_pkg::i_rrmovq) || (f_icode == y86_pkg::i_irmovq) ||
		(f_icode == y86_pkg::i_opq);
	assign need_valc = (f_icode == y86_pkg::i_irmovq) || (f_icode == y86_pkg::i_jxx);

	assign f_ra = need_regids ? ibytes[1][7:4] : y86_pkg::rnone;
	assign f_rb = need_regids ? ibytes[1][3:0] : y86_pkg::rnone;

	always_comb
	begin
		for (int k = 0; k < 8; k++)
			f_valc[8*k +: 8] = need_regids ? ibytes[k+2] : ibytes[k+1]; // little endian
	end

	assign f_valp = f_pc + 64'd1 + (need_regids ? 64'd1 : 64'd0) + (need_valc ? 64'd8 : 64'd0);
	assign f_pred = (f_icode == y86_pkg::i_jxx) ? f_valc : f_valp; // always taken

	always_comb
	begin
		case (f_icode)
			y86_pkg::i_halt, y86_pkg::i_nop, y86_pkg::i_irmovq: instr_valid = (f_ifun == 4'h0);
			y86_pkg::i_rrmovq: instr_valid = (f_ifun <= 4'h6);
			y86_pkg::i_jxx:    instr_valid = (f_ifun <= 4'h6);
			y86_pkg::i_opq:    instr_valid = (f_ifun <= 4'h3);
			default:           instr_valid = 1'b0;
		endcase
	end

	always_comb
	begin
		if (imem_error)
			f_stat = y86_pkg::s_adr;
		else if (!instr_valid)
			f_stat = y86_pkg::s_ins;
		else if (f_icode == y86_pkg::i_halt)
			f_stat = y86_pkg::s_hlt;
		else
			f_stat = y86_pkg::s_aok;
	end

	assign frozen = (w_stat != y86_pkg::s_aok);

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
			pred_pc <= '0;
		else if (!frozen)
			pred_pc <= mispredict ? redirect_pc : f_pred; // fall-through fetched after two bubbles
	end

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			d_stat <= y86_pkg::s_aok;
			d_icode <= y86_pkg::i_nop;
			d_ifun <= 4'h0;
			d_ra <= y86_pkg::rnone;
			d_rb <= y86_pkg::rnone;
			d_valc <= '0;
			d_valp <= '0;
		end
		else if (frozen)
		begin
			d_stat <= d_stat; // hold everything
		end
		else if (mispredict)
		begin
			d_stat <= y86_pkg::s_aok;
			d_icode <= y86_pkg::i_nop;
			d_ra <= y86_pkg::rnone;
			d_rb <= y86_pkg::rnone;
		end
		else
		begin
			d_stat <= f_stat;
			d_icode <= f_icode;
			d_ifun <= f_ifun;
			d_ra <= f_ra;
			d_rb <= f_rb;
			d_valc <= f_valc;
			d_valp <= f_valp;
		end
	end

endmodule

/* hdl/y86_decode.sv */
`timescale 1ns/1ps

module y86_decode (
	input  logic                             CLK,
	input  logic                             reset,
	input  y86_pkg::stat_t                   d_stat,
	input  y86_pkg::icode_t                  d_icode,
	input  logic [3:0]                       d_ifun,
	input  logic [y86_pkg::reg_w-1:0]        d_ra,
	input  logic [y86_pkg::reg_w-1:0]        d_rb,
	input  logic [y86_pkg::word_w-1:0]       d_valc,
	input  logic [y86_pkg::pc_w-1:0]         d_valp,
	input  logic                             mispredict,
	input  logic [y86_pkg::word_w-1:0]       x_val,
	input  logic [y86_pkg::reg_w-1:0]        x_dst,
	input  logic [y86_pkg::reg_w-1:0]        wb_dst,
	input  logic [y86_pkg::word_w-1:0]       wb_val,
	output y86_pkg::stat_t                   e_stat,
	output y86_pkg::icode_t                  e_icode,
	output logic [3:0]                       e_ifun,
	output logic [y86_pkg::word_w-1:0]       e_valc,
	output logic [y86_pkg::word_w-1:0]       e_vala,
	output logic [y86_pkg::word_w-1:0]       e_valb,
	output logic [y86_pkg::reg_w-1:0]        e_dst
);

	logic [y86_pkg::word_w-1:0] rf [15];

	logic [y86_pkg::reg_w-1:0]  src_a;
	logic [y86_pkg::reg_w-1:0]  src_b;
	logic [y86_pkg::reg_w-1:0]  dst;
	logic [y86_pkg::word_w-1:0] val_a;
	logic [y86_pkg::word_w-1:0] val_b;

	// newest producer wins
	function automatic logic [y86_pkg::word_w-1:0] fwd(
		input logic [y86_pkg::reg_w-1:0]  src,
		input logic [y86_pkg::reg_w-1:0]  xd,
		input logic [y86_pkg::word_w-1:0] xv,
		input logic [y86_pkg::reg_w-1:0]  wd,
		input logic [y86_pkg::word_w-1:0] wv,
		input logic [y86_pkg::word_w-1:0] rv
	);
		if (src == y86_pkg::rnone)
			return '0;
		else if (src == xd)
			return xv;
		else if (src == wd)
			return wv;
		else
			return rv;
	endfunction

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < 15; i++)
				rf[i] <= '0;
		end
		else if (wb_dst != y86_pkg::rnone)
			rf[wb_dst] <= wb_val;
	end

	always_comb
	begin
		src_a = y86_pkg::rnone;
		src_b = y86_pkg::rnone;
		dst = y86_pkg::rnone;
		case (d_icode)
			y86_pkg::i_rrmovq:
			begin
				src_a = d_ra;
				dst = d_rb;
			end
			y86_pkg::i_irmovq: dst = d_rb;
			y86_pkg::i_opq:
			begin
				src_a = d_ra;
				src_b = d_rb;
				dst = d_rb;
			end
			default: dst = y86_pkg::rnone;
		endcase
	end

	// rnone never matches an index below 15
	assign val_a = (d_icode == y86_pkg::i_jxx) ? d_valp :
		fwd(src_a, x_dst, x_val, wb_dst, wb_val, rf[src_a]);
	assign val_b = fwd(src_b, x_dst, x_val, wb_dst, wb_val, rf[src_b]);

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset || mispredict)
		begin
			e_stat <= y86_pkg::s_aok;
			e_icode <= y86_pkg::i_nop;
			e_ifun <= 4'h0;
			e_valc <= '0;
			e_vala <= '0;
			e_valb <= '0;
			e_dst <= y86_pkg::rnone;
		end
		else
		begin
			e_stat <= d_stat;
			e_icode <= d_icode;
			e_ifun <= d_ifun;
			e_valc <= d_valc;
			e_vala <= val_a;
			e_valb <= val_b;
			e_dst <= dst;
		end
	end

endmodule

/* hdl/y86_execute.sv */
`timescale 1ns/1ps

module y86_execute (
	input  logic                             CLK,
	input  logic                             reset,
	input  y86_pkg::stat_t                   e_stat,
	input  y86_pkg::icode_t                  e_icode,
	input  logic [3:0]                       e_ifun,
	input  logic [y86_pkg::word_w-1:0]       e_valc,
	input  logic [y86_pkg::word_w-1:0]       e_vala,
	input  logic [y86_pkg::word_w-1:0]       e_valb,
	input  logic [y86_pkg::reg_w-1:0]        e_dst,
	input  y86_pkg::stat_t                   w_stat,
	output logic [y86_pkg::word_w-1:0]       x_val,
	output logic [y86_pkg::reg_w-1:0]        x_dst,
	output y86_pkg::stat_t                   x_stat,
	output logic                             mispredict,
	output logic [y86_pkg::pc_w-1:0]         redirect_pc
);

	logic [y86_pkg::word_w-1:0] alu_a;
	logic [y86_pkg::word_w-1:0] alu_b;
	logic [y86_pkg::word_w-1:0] alu_res;
	y86_pkg::alu_fun_t          alu_fun;
	logic set_cc;
	logic new_of;
	logic cnd;
	logic zf;
	logic sf;
	logic of;

	always_comb
	begin
		case (e_icode)
			y86_pkg::i_rrmovq:
			begin
				alu_a = e_vala;
				alu_b = '0;
			end
			y86_pkg::i_irmovq:
			begin
				alu_a = e_valc;
				alu_b = '0;
			end
			y86_pkg::i_opq:
			begin
				alu_a = e_vala;
				alu_b = e_valb;
			end
			default:
			begin
				alu_a = '0;
				alu_b = '0;
			end
		endcase
	end

	assign alu_fun = (e_icode == y86_pkg::i_opq) ? y86_pkg::alu_fun_t'(e_ifun) : y86_pkg::alu_add;

	always_comb
	begin
		case (alu_fun)
			y86_pkg::alu_add: alu_res = alu_b + alu_a;
			y86_pkg::alu_sub: alu_res = alu_b - alu_a; // rB - rA
			y86_pkg::alu_and: alu_res = alu_b & alu_a;
			y86_pkg::alu_xor: alu_res = alu_b ^ alu_a;
			default:          alu_res = '0;
		endcase
	end

	// signed overflow, logic ops clear it
	always_comb
	begin
		case (alu_fun)
			y86_pkg::alu_add: new_of = (alu_a[63] == alu_b[63]) && (alu_res[63] != alu_a[63]);
			y86_pkg::alu_sub: new_of = (alu_a[63] != alu_b[63]) && (alu_res[63] != alu_b[63]);
			default:          new_of = 1'b0;
		endcase
	end

	// no cc change behind a stopped instruction
	assign set_cc = (e_icode == y86_pkg::i_opq) && (e_stat == y86_pkg::s_aok) &&
		(w_stat == y86_pkg::s_aok);

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			zf <= 1'b0;
			sf <= 1'b0;
			of <= 1'b0;
		end
		else if (set_cc)
		begin
			zf <= (alu_res == '0);
			sf <= alu_res[63];
			of <= new_of;
		end
	end

	always_comb
	begin
		case (y86_pkg::cond_t'(e_ifun))
			y86_pkg::c_always: cnd = 1'b1;
			y86_pkg::c_le:     cnd = (sf ^ of) | zf;
			y86_pkg::c_l:      cnd = sf ^ of;
			y86_pkg::c_e:      cnd = zf;
			y86_pkg::c_ne:     cnd = ~zf;
			y86_pkg::c_ge:     cnd = ~(sf ^ of);
			y86_pkg::c_g:      cnd = ~(sf ^ of) & ~zf;
			default:           cnd = 1'b0;
		endcase
	end

	assign x_val = alu_res;
	assign x_dst = (e_icode == y86_pkg::i_rrmovq && !cnd) ? y86_pkg::rnone : e_dst;
	assign x_stat = e_stat;

	// predicted taken, so a failed condition means fall through
	assign mispredict = (e_icode == y86_pkg::i_jxx) && !cnd && (e_stat == y86_pkg::s_aok);
	assign redirect_pc = e_vala; // valP of the jump

endmodule

/* hdl/y86_result.sv */
`timescale 1ns/1ps

module y86_result (
	input  logic                             CLK,
	input  logic                             reset,
	input  logic [y86_pkg::word_w-1:0]       x_val,
	input  logic [y86_pkg::reg_w-1:0]        x_dst,
	input  y86_pkg::stat_t                   x_stat,
	output y86_pkg::stat_t                   w_stat,
	output logic                             wb_valid,
	output logic [y86_pkg::reg_w-1:0]        wb_dst,
	output logic [y86_pkg::word_w-1:0]       wb_val,
	output y86_pkg::stat_t                   stat
);

	logic [y86_pkg::word_w-1:0] w_val;
	logic [y86_pkg::reg_w-1:0]  w_dst;

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			w_stat <= y86_pkg::s_aok;
			w_dst <= y86_pkg::rnone;
			w_val <= '0;
		end
		else if (w_stat == y86_pkg::s_aok) // frozen once stopped
		begin
			w_stat <= x_stat;
			w_dst <= x_dst;
			w_val <= x_val;
		end
	end

	// stopping instruction commits nothing
	assign wb_dst = (w_stat == y86_pkg::s_aok) ? w_dst : y86_pkg::rnone;
	assign wb_valid = (w_stat == y86_pkg::s_aok) && (w_dst != y86_pkg::rnone);
	assign wb_val = w_val;
	assign stat = w_stat;

endmodule

/* hdl/y86_core.sv */
`timescale 1ns/1ps

module y86_core (
	input  logic                             CLK,
	input  logic                             reset,
	input  logic                             prog_we,
	input  logic [7:0]                       prog_addr,
	input  logic [7:0]                       prog_data,
	output logic                             wb_valid,
	output logic [y86_pkg::reg_w-1:0]        wb_dst,
	output logic [y86_pkg::word_w-1:0]       wb_val,
	output y86_pkg::stat_t                   stat
);

	// D register
	y86_pkg::stat_t                   d_stat;
	y86_pkg::icode_t                  d_icode;
	logic [3:0]                       d_ifun;
	logic [y86_pkg::reg_w-1:0]        d_ra;
	logic [y86_pkg::reg_w-1:0]        d_rb;
	logic [y86_pkg::word_w-1:0]       d_valc;
	logic [y86_pkg::pc_w-1:0]         d_valp;

	// E register
	y86_pkg::stat_t                   e_stat;
	y86_pkg::icode_t                  e_icode;
	logic [3:0]                       e_ifun;
	logic [y86_pkg::word_w-1:0]       e_valc;
	logic [y86_pkg::word_w-1:0]       e_vala;
	logic [y86_pkg::word_w-1:0]       e_valb;
	logic [y86_pkg::reg_w-1:0]        e_dst;

	// execute results
	logic [y86_pkg::word_w-1:0]       x_val;
	logic [y86_pkg::reg_w-1:0]        x_dst;
	y86_pkg::stat_t                   x_stat;
	logic                             mispredict;
	logic [y86_pkg::pc_w-1:0]         redirect_pc;

	y86_pkg::stat_t                   w_stat;

	y86_fetch fetch_inst (
		.CLK(CLK), .reset(reset),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.mispredict(mispredict), .redirect_pc(redirect_pc), .w_stat(w_stat),
		.d_stat(d_stat), .d_icode(d_icode), .d_ifun(d_ifun),
		.d_ra(d_ra), .d_rb(d_rb), .d_valc(d_valc), .d_valp(d_valp)
	);

	y86_decode decode_inst (
		.CLK(CLK), .reset(reset),
		.d_stat(d_stat), .d_icode(d_icode), .d_ifun(d_ifun),
		.d_ra(d_ra), .d_rb(d_rb), .d_valc(d_valc), .d_valp(d_valp),
		.mispredict(mispredict), .x_val(x_val), .x_dst(x_dst),
		.wb_dst(wb_dst), .wb_val(wb_val),
		.e_stat(e_stat), .e_icode(e_icode), .e_ifun(e_ifun), .e_valc(e_valc),
		.e_vala(e_vala), .e_valb(e_valb), .e_dst(e_dst)
	);

	y86_execute execute_inst (
		.CLK(CLK), .reset(reset),
		.e_stat(e_stat), .e_icode(e_icode), .e_ifun(e_ifun), .e_valc(e_valc),
		.e_vala(e_vala), .e_valb(e_valb), .e_dst(e_dst), .w_stat(w_stat),
		.x_val(x_val), .x_dst(x_dst), .x_stat(x_stat),
		.mispredict(mispredict), .redirect_pc(redirect_pc)
	);

	y86_result result_inst (
		.CLK(CLK), .reset(reset),
		.x_val(x_val), .x_dst(x_dst), .x_stat(x_stat),
		.w_stat(w_stat), .wb_valid(wb_valid), .wb_dst(wb_dst), .wb_val(wb_val),
		.stat(stat)
	);

endmodule

/* test/y86_core_props.sv */
`timescale 1ns/1ps

module y86_core_props (
	input logic                        CLK,
	input logic                        reset,
	input logic                        wb_valid,
	input logic [y86_pkg::reg_w-1:0]   wb_dst,
	input y86_pkg::stat_t              stat
);

	int assert_fails = 0;

	// write pulse and register file write agree
	assert property (@(posedge CLK) disable iff (reset)
		wb_valid == (wb_dst != y86_pkg::rnone))
	else
	begin
		assert_fails++;
		$error("write port valid and destination register disagree");
	end

	// stop status is sticky until reset
	assert property (@(posedge CLK) disable iff (reset)
		(stat != y86_pkg::s_aok) |=> $stable(stat))
	else
	begin
		assert_fails++;
		$error("stop status changed before reset");
	end

	assert property (@(posedge CLK) disable iff (reset)
		(stat != y86_pkg::s_aok) |-> !wb_valid)
	else
	begin
		assert_fails++;
		$error("register write after the core stopped");
	end

endmodule

bind y86_core y86_core_props props_inst (
	.CLK(CLK),
	.reset(reset),
	.wb_valid(wb_valid),
	.wb_dst(wb_dst),
	.stat(stat)
);

/* test/y86_core_tb.sv */
`timescale 1ns/1ps

module y86_core_tb;

	logic                         CLK;
	logic                         reset;
	logic                         prog_we;
	logic [7:0]                   prog_addr;
	logic [7:0]                   prog_data;
	logic                         wb_valid;
	logic [y86_pkg::reg_w-1:0]    wb_dst;
	logic [y86_pkg::word_w-1:0]   wb_val;
	y86_pkg::stat_t               stat;

	// one row per test
	logic [7:0]                   prog_bytes [8][32];
	y86_pkg::stat_t               exp_stat [8];
	logic [y86_pkg::reg_w-1:0]    exp_reg [8];
	logic [y86_pkg::word_w-1:0]   exp_val [8];
	int                           exp_writes [8];

	int num_tests;
	int fill_pos;
	int errors;
	int failed_tests;

	y86_core y86_core_inst (
		.CLK(CLK),
		.reset(reset),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.wb_valid(wb_valid),
		.wb_dst(wb_dst),
		.wb_val(wb_val),
		.stat(stat)
	);

	always #10 CLK = ~CLK;

	task automatic start_program();
		fill_pos = 0;
		for (int k = 0; k < 32; k++)
			prog_bytes[num_tests][k] = 8'h00; // halt padding
	endtask

	task automatic append_byte(input logic [7:0] b);
		prog_bytes[num_tests][fill_pos] = b;
		fill_pos++;
	endtask

	task automatic quad_bytes(input logic [63:0] v);
		for (int k = 0; k < 8; k++)
			append_byte(v[8*k +: 8]); // little endian
	endtask

	task automatic irmovq_instr(input logic [63:0] v, input logic [3:0] rb);
		append_byte({y86_pkg::i_irmovq, 4'h0});
		append_byte({y86_pkg::rnone, rb});
		quad_bytes(v);
	endtask

	task automatic reg_pair_instr(input logic [3:0] icode, input logic [3:0] fun,
		input logic [3:0] ra, input logic [3:0] rb);
		append_byte({icode, fun});
		append_byte({ra, rb});
	endtask

	task automatic jump_instr(input logic [3:0] cond, input logic [63:0] dest);
		append_byte({y86_pkg::i_jxx, cond});
		quad_bytes(dest);
	endtask

	task automatic expect_result(input y86_pkg::stat_t st, input logic [3:0] r,
		input logic [63:0] v, input int n);
		exp_stat[num_tests] = st;
		exp_reg[num_tests] = r;
		exp_val[num_tests] = v;
		exp_writes[num_tests] = n;
		num_tests++;
	endtask

	// register ids rax 0, rcx 1, rdx 2, rbx 3, rsi 6, rdi 7, r8 8
	task automatic build_table();
		// dependent OPq chain
		start_program();
		irmovq_instr(64'h10, 4'h0);
		irmovq_instr(64'h3, 4'h1);
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_add, 4'h0, 4'h1); // rcx 0x13
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_sub, 4'h1, 4'h0); // rax -3
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_and, 4'h0, 4'h1); // rcx 0x11
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_xor, 4'h1, 4'h0);
		expect_result(y86_pkg::s_hlt, 4'h0, 64'hffff_ffff_ffff_ffec, 6);

		// cmov on ZF from a subq giving zero
		start_program();
		irmovq_instr(64'h5, 4'h0);
		irmovq_instr(64'h5, 4'h1);
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_sub, 4'h0, 4'h1);
		reg_pair_instr(y86_pkg::i_rrmovq, y86_pkg::c_e, 4'h0, 4'h2);  // moves 5
		reg_pair_instr(y86_pkg::i_rrmovq, y86_pkg::c_ne, 4'h1, 4'h2); // no move
		reg_pair_instr(y86_pkg::i_rrmovq, y86_pkg::c_ge, 4'h1, 4'h3);
		expect_result(y86_pkg::s_hlt, 4'h2, 64'h5, 5);

		// jne loop where rcx doubles until it carries out to zero
		start_program();
		irmovq_instr(64'h1000_0000_0000_0000, 4'h1);
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_add, 4'h1, 4'h0); // 0x0a
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_add, 4'h1, 4'h1);
		jump_instr(y86_pkg::c_ne, 64'h0a);
		expect_result(y86_pkg::s_hlt, 4'h0, 64'hf000_0000_0000_0000, 9);

		// je not taken while the target holds two adds that must not commit
		start_program();
		irmovq_instr(64'h1, 4'h0);
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_and, 4'h0, 4'h0);
		jump_instr(y86_pkg::c_e, 64'h1b);
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_add, 4'h0, 4'h2); // fall through
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_add, 4'h0, 4'h2);
		append_byte(8'h00);
		append_byte(8'h00);
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_add, 4'h0, 4'h2); // 0x1b
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_add, 4'h0, 4'h2);
		expect_result(y86_pkg::s_hlt, 4'h2, 64'h2, 4);

		// jmp over a write and halt with a write behind it
		start_program();
		irmovq_instr(64'h2a, 4'h3);
		jump_instr(y86_pkg::c_always, 64'h15);
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_add, 4'h3, 4'h3); // skipped
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_add, 4'h3, 4'h3);
		append_byte({y86_pkg::i_halt, 4'h0});
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_add, 4'h3, 4'h3);
		expect_result(y86_pkg::s_hlt, 4'h3, 64'h54, 2);

		// invalid icode
		start_program();
		irmovq_instr(64'hffff_ffff_ffff_fff8, 4'h6);
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_add, 4'h6, 4'h6);
		append_byte({y86_pkg::i_call, 4'h0});
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_add, 4'h6, 4'h6);
		expect_result(y86_pkg::s_ins, 4'h6, 64'hffff_ffff_ffff_fff0, 2);

		// invalid cmov function
		start_program();
		irmovq_instr(64'h3, 4'h8);
		reg_pair_instr(y86_pkg::i_rrmovq, 4'h7, 4'h0, 4'h8);
		expect_result(y86_pkg::s_ins, 4'h8, 64'h3, 1);

		// jump past the last program byte
		start_program();
		irmovq_instr(64'h11, 4'h7);
		jump_instr(y86_pkg::c_always, 64'h100);
		reg_pair_instr(y86_pkg::i_opq, y86_pkg::alu_add, 4'h7, 4'h7);
		expect_result(y86_pkg::s_adr, 4'h7, 64'h11, 1);
	endtask

	task automatic load_program(input int t);
		@(negedge CLK);
		reset = 1'b1;
		for (int k = 0; k < 32; k++)
		begin
			@(negedge CLK);
			prog_we = 1'b1;
			prog_addr = 8'(k);
			prog_data = prog_bytes[t][k];
		end
		@(negedge CLK);
		prog_we = 1'b0;
		repeat (5) @(negedge CLK);
		reset = 1'b0;
	endtask

	task automatic run_program(input int t);
		int writes;
		int extra;
		int test_errors;
		logic seen;
		logic [63:0] last_val;
		writes = 0;
		extra = 0;
		test_errors = 0;
		seen = 1'b0;
		last_val = '0;
		if (wb_valid !== 1'b0 || stat !== y86_pkg::s_aok)
		begin
			$display("[ERROR] %0t ns: test %0d not idle after reset, wb_valid %b stat %0d",
				$time, t, wb_valid, stat);
			test_errors++;
		end
		// a few cycles past the stop to catch late commits
		while (extra < 4)
		begin
			@(negedge CLK);
			if (wb_valid === 1'b1)
			begin
				writes++;
				if (wb_dst == exp_reg[t])
				begin
					last_val = wb_val;
					seen = 1'b1;
				end
			end
			if (stat !== y86_pkg::s_aok)
				extra++;
		end
		if (stat !== exp_stat[t])
		begin
			$display("[ERROR] %0t ns: test %0d stat %0d, expected %0d",
				$time, t, stat, exp_stat[t]);
			test_errors++;
		end
		if (writes != exp_writes[t])
		begin
			$display("[ERROR] %0t ns: test %0d committed %0d writes, expected %0d",
				$time, t, writes, exp_writes[t]);
			test_errors++;
		end
		if (!seen)
		begin
			$display("test %0d: register %0d was never written", t, exp_reg[t]);
			test_errors++;
		end
		else if (last_val !== exp_val[t])
		begin
			$display("[ERROR] %0t ns: test %0d register %0d got %h, expected %h",
				$time, t, exp_reg[t], last_val, exp_val[t]);
			test_errors++;
		end
		errors += test_errors;
		if (test_errors == 0)
			$display("test %0d: ok, %0d writes, stat %0d", t, writes, stat);
		else
		begin
			failed_tests++;
			$display("test %0d: wrong, %0d errors", t, test_errors);
		end
	endtask

	initial
	begin
		CLK = 1'b0;
		reset = 1'b1;
		prog_we = 1'b0;
		prog_addr = 8'h00;
		prog_data = 8'h00;
		errors = 0;
		failed_tests = 0;
		num_tests = 0;
		build_table();
		for (int t = 0; t < num_tests; t++)
		begin
			load_program(t);
			run_program(t);
		end
		if (y86_core_inst.props_inst.assert_fails != 0)
			$display("bound assertions failed %0d times",
				y86_core_inst.props_inst.assert_fails);
		errors += y86_core_inst.props_inst.assert_fails;
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			num_tests, num_tests - failed_tests, failed_tests, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// watchdog with 80 cycles per test plus margin
	initial
	begin
		wait (num_tests > 0);
		#((num_tests * 80 + 100) * 20);
		$display("timeout: the core did not reach a stop status in time");
		$display("Verification failed");
		$finish;
	end

endmodule

/* y86_core.f */
hdl/y86_pkg.sv
hdl/y86_fetch.sv
hdl/y86_decode.sv
hdl/y86_execute.sv
hdl/y86_result.sv
hdl/y86_core.sv
test/y86_core_props.sv
test/y86_core_tb.sv
